// ==== logic/pea_pkg.sv ====
package pea_pkg;

  ////////////////////////////////////////////////////////////
  // Array geometry and word width
  ////////////////////////////////////////////////////////////

  localparam int N_BITS = 32;
  localparam int N_ROWS = 4;
  localparam int N_COLS = 4;

  // Operand sources seen by every PE
  localparam int N_SRC = 6;

  // Shift amount taken from operand B
  localparam int SHAMT_W = 5;

  ////////////////////////////////////////////////////////////
  // PE configuration
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ADD  = 3'd0,
    SUB  = 3'd1,
    MUL  = 3'd2,
    AND  = 3'd3,
    OR   = 3'd4,
    XOR  = 3'd5,
    SHL  = 3'd6,
    PASS = 3'd7
  } pe_op_e;

  // Codes 6 and 7 select a valid zero
  typedef enum logic [2:0] {
    SRC_STREAM = 3'd0,
    SRC_CONST  = 3'd1,
    SRC_NORTH  = 3'd2,
    SRC_WEST   = 3'd3,
    SRC_EAST   = 3'd4,
    SRC_SOUTH  = 3'd5
  } pe_src_e;

  typedef struct packed {
    pe_op_e  op;
    pe_src_e src_a;
    pe_src_e src_b;
  } pe_ctrl_t;

  // Column grouping of the ready, 3 behaves as TWIN
  typedef enum logic [1:0] {
    READY_ALL    = 2'd0,
    READY_SINGLE = 2'd1,
    READY_TWIN   = 2'd2
  } ready_mode_e;

endpackage

// ==== logic/pea_stream_in.sv ====
`timescale 1ns/1ps

module pea_stream_in
  import pea_pkg::*;
#(
  parameter int N_COLS = pea_pkg::N_COLS,
  parameter int N_BITS = pea_pkg::N_BITS
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  ready_mode_e                   ready_mode_i,
  input  logic [N_COLS-1:0]             stream_ready_i,
  input  logic [N_COLS-1:0]             stream_valid_i,
  input  logic [N_COLS-1:0][N_BITS-1:0] stream_data_i,
  output logic [N_COLS-1:0]             col_en_o,
  output logic [N_COLS-1:0]             in_valid_o,
  output logic [N_COLS-1:0][N_BITS-1:0] in_data_o
);

  logic              ready_all;
  logic [N_COLS-1:0] ready_twin;

  assign ready_all = &stream_ready_i;

  // Pairs 2k and 2k+1, an odd last column stands alone
  for (genvar c = 0; c < N_COLS; c++) begin : gen_twin
    localparam int MATE = c ^ 1;
    if (MATE < N_COLS) begin : gen_pair
      assign ready_twin[c] = stream_ready_i[c] & stream_ready_i[MATE];
    end else begin : gen_alone
      assign ready_twin[c] = stream_ready_i[c];
    end
  end

  always_comb begin
    case (ready_mode_i)
      READY_ALL:    col_en_o = {N_COLS{ready_all}};
      READY_SINGLE: col_en_o = stream_ready_i;
      default:      col_en_o = ready_twin;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Input registers
  ////////////////////////////////////////////////////////////

  // Idle input cycles enter as invalid slots
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_valid_o <= '0;
      in_data_o  <= '0;
    end else begin
      for (int c = 0; c < N_COLS; c++) begin
        if (col_en_o[c]) begin
          in_valid_o[c] <= stream_valid_i[c];
          in_data_o[c]  <= stream_data_i[c];
        end
      end
    end
  end

endmodule

// ==== logic/pe.sv ====
`timescale 1ns/1ps

module pe
  import pea_pkg::*;
#(
  parameter int N_BITS = pea_pkg::N_BITS
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         en_i,
  input  pe_ctrl_t                     ctrl_i,
  input  logic [N_SRC-1:0][N_BITS-1:0] src_data_i,
  input  logic [N_SRC-1:0]             src_valid_i,
  output logic [N_BITS-1:0]            res_o,
  output logic                         valid_o
);

  // Index 0 is operand A, index 1 is operand B
  logic [2:0]        op_sel   [2];
  logic [N_BITS-1:0] op_data  [2];
  logic              op_valid [2];

  logic [N_BITS-1:0] alu_res;

  assign op_sel[0] = ctrl_i.src_a;
  assign op_sel[1] = ctrl_i.src_b;

  ////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < 2; k++) begin : gen_operand
    always_comb begin
      if (op_sel[k] < 3'(N_SRC)) begin
        op_data[k]  = src_data_i[op_sel[k]];
        op_valid[k] = src_valid_i[op_sel[k]];
      end else begin
        // Unused codes feed a zero that never stalls
        op_data[k]  = '0;
        op_valid[k] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i.op)
      ADD: begin
        alu_res = op_data[0] + op_data[1];
      end
      SUB: begin
        alu_res = op_data[0] - op_data[1];
      end
      MUL: begin
        // Low half of the product
        alu_res = op_data[0] * op_data[1];
      end
      AND: begin
        alu_res = op_data[0] & op_data[1];
      end
      OR: begin
        alu_res = op_data[0] | op_data[1];
      end
      XOR: begin
        alu_res = op_data[0] ^ op_data[1];
      end
      SHL: begin
        alu_res = op_data[0] << op_data[1][SHAMT_W-1:0];
      end
      PASS: begin
        alu_res = op_data[0];
      end
      default: begin
        alu_res = op_data[0];
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////

  // Column enable low holds result and valid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_o   <= '0;
      valid_o <= 1'b0;
    end else if (en_i) begin
      res_o   <= alu_res;
      valid_o <= op_valid[0] & op_valid[1];
    end
  end

endmodule

// ==== logic/pea_interconnect.sv ====
`timescale 1ns/1ps

module pea_interconnect
  import pea_pkg::*;
#(
  parameter int N_ROWS = pea_pkg::N_ROWS,
  parameter int N_COLS = pea_pkg::N_COLS,
  parameter int N_BITS = pea_pkg::N_BITS
) (
  input  logic [N_COLS-1:0][N_BITS-1:0]                        in_data_i,
  input  logic [N_COLS-1:0]                                    in_valid_i,
  input  logic [N_ROWS-1:0][N_COLS-1:0][N_BITS-1:0]            const_op_i,
  input  logic [N_ROWS-1:0][N_COLS-1:0][N_BITS-1:0]            pe_res_i,
  input  logic [N_ROWS-1:0][N_COLS-1:0]                        pe_valid_i,
  input  logic [N_COLS-1:0][$clog2(N_ROWS+1)-1:0]              out_row_sel_i,
  output logic [N_ROWS-1:0][N_COLS-1:0][N_SRC-1:0][N_BITS-1:0] src_data_o,
  output logic [N_ROWS-1:0][N_COLS-1:0][N_SRC-1:0]             src_valid_o,
  output logic [N_COLS-1:0][N_BITS-1:0]                        stream_data_o,
  output logic [N_COLS-1:0]                                    stream_valid_o
);

  localparam int SEL_W = $clog2(N_ROWS + 1);

  // Grid of results with a one-PE ring of valid zeros around it
  logic [N_BITS-1:0] res_pad [N_ROWS+2][N_COLS+2];
  logic              val_pad [N_ROWS+2][N_COLS+2];

  always_comb begin
    for (int r = 0; r < N_ROWS + 2; r++) begin
      for (int c = 0; c < N_COLS + 2; c++) begin
        res_pad[r][c] = '0;
        val_pad[r][c] = 1'b1;
      end
    end
    for (int r = 0; r < N_ROWS; r++) begin
      for (int c = 0; c < N_COLS; c++) begin
        res_pad[r+1][c+1] = pe_res_i[r][c];
        val_pad[r+1][c+1] = pe_valid_i[r][c];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand vectors
  ////////////////////////////////////////////////////////////

  // PE (r, c) sits at (r+1, c+1) in the padded grid
  always_comb begin
    for (int r = 0; r < N_ROWS; r++) begin
      for (int c = 0; c < N_COLS; c++) begin
        src_data_o[r][c][SRC_STREAM]  = in_data_i[c];
        src_valid_o[r][c][SRC_STREAM] = in_valid_i[c];
        src_data_o[r][c][SRC_CONST]   = const_op_i[r][c];
        src_valid_o[r][c][SRC_CONST]  = 1'b1;
        src_data_o[r][c][SRC_NORTH]   = res_pad[r][c+1];
        src_valid_o[r][c][SRC_NORTH]  = val_pad[r][c+1];
        src_data_o[r][c][SRC_WEST]    = res_pad[r+1][c];
        src_valid_o[r][c][SRC_WEST]   = val_pad[r+1][c];
        src_data_o[r][c][SRC_EAST]    = res_pad[r+1][c+2];
        src_valid_o[r][c][SRC_EAST]   = val_pad[r+1][c+2];
        src_data_o[r][c][SRC_SOUTH]   = res_pad[r+2][c+1];
        src_valid_o[r][c][SRC_SOUTH]  = val_pad[r+2][c+1];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Column output select
  ////////////////////////////////////////////////////////////

  // Selector N and above give an idle zero word
  always_comb begin
    for (int c = 0; c < N_COLS; c++) begin
      stream_data_o[c]  = '0;
      stream_valid_o[c] = 1'b0;
      for (int r = 0; r < N_ROWS; r++) begin
        if (out_row_sel_i[c] == SEL_W'(r)) begin
          stream_data_o[c]  = pe_res_i[r][c];
          stream_valid_o[c] = pe_valid_i[r][c];
        end
      end
    end
  end

endmodule

// ==== logic/pea.sv ====
`timescale 1ns/1ps

module pea
  import pea_pkg::*;
#(
  parameter int N_ROWS = pea_pkg::N_ROWS,
  parameter int N_COLS = pea_pkg::N_COLS,
  parameter int N_BITS = pea_pkg::N_BITS
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  ready_mode_e                               ready_mode_i,
  input  logic [N_COLS-1:0][$clog2(N_ROWS+1)-1:0]   out_row_sel_i,
  input  pe_ctrl_t [N_ROWS-1:0][N_COLS-1:0]         ctrl_pea_i,
  input  logic [N_ROWS-1:0][N_COLS-1:0][N_BITS-1:0] const_op_i,
  input  logic [N_COLS-1:0]                         stream_valid_i,
  input  logic [N_COLS-1:0][N_BITS-1:0]             stream_data_i,
  input  logic [N_COLS-1:0]                         stream_ready_i,
  output logic [N_COLS-1:0]                         pea_ready_o,
  output logic [N_COLS-1:0]                         stream_valid_o,
  output logic [N_COLS-1:0][N_BITS-1:0]             stream_data_o
);

  logic [N_COLS-1:0]                                    col_en;
  logic [N_COLS-1:0]                                    in_valid;
  logic [N_COLS-1:0][N_BITS-1:0]                        in_data;
  logic [N_ROWS-1:0][N_COLS-1:0][N_BITS-1:0]            pe_res;
  logic [N_ROWS-1:0][N_COLS-1:0]                        pe_valid;
  logic [N_ROWS-1:0][N_COLS-1:0][N_SRC-1:0][N_BITS-1:0] src_data;
  logic [N_ROWS-1:0][N_COLS-1:0][N_SRC-1:0]             src_valid;

  // Group ready doubles as the column enable
  assign pea_ready_o = col_en;

  pea_stream_in #(
    .N_COLS (N_COLS),
    .N_BITS (N_BITS)
  ) u_stream_in (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ready_mode_i   (ready_mode_i),
    .stream_ready_i (stream_ready_i),
    .stream_valid_i (stream_valid_i),
    .stream_data_i  (stream_data_i),
    .col_en_o       (col_en),
    .in_valid_o     (in_valid),
    .in_data_o      (in_data)
  );

  pea_interconnect #(
    .N_ROWS (N_ROWS),
    .N_COLS (N_COLS),
    .N_BITS (N_BITS)
  ) u_interconnect (
    .in_data_i      (in_data),
    .in_valid_i     (in_valid),
    .const_op_i     (const_op_i),
    .pe_res_i       (pe_res),
    .pe_valid_i     (pe_valid),
    .out_row_sel_i  (out_row_sel_i),
    .src_data_o     (src_data),
    .src_valid_o    (src_valid),
    .stream_data_o  (stream_data_o),
    .stream_valid_o (stream_valid_o)
  );

  ////////////////////////////////////////////////////////////
  // PE grid
  ////////////////////////////////////////////////////////////

  for (genvar r = 0; r < N_ROWS; r++) begin : gen_row
    for (genvar c = 0; c < N_COLS; c++) begin : gen_col
      pe #(
        .N_BITS (N_BITS)
      ) u_pe (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .en_i        (col_en[c]),
        .ctrl_i      (ctrl_pea_i[r][c]),
        .src_data_i  (src_data[r][c]),
        .src_valid_i (src_valid[r][c]),
        .res_o       (pe_res[r][c]),
        .valid_o     (pe_valid[r][c])
      );
    end
  end

endmodule

// ==== tb/tb_pea_cases.svh ====
////////////////////////////////////////////////////////////
// Case table
////////////////////////////////////////////////////////////

// Columns: mode, layout, row 0 op per column, row select per column,
// words per column, ready drop percent per column
task automatic load_cases();
  // Every operation on stream and constant
  add_case(READY_ALL, LAYOUT_ROW0, ADD, SUB, MUL, AND,
           0, 0, 0, 0, 24, 0);
  add_case(READY_ALL, LAYOUT_ROW0, OR, XOR, SHL, PASS,
           0, 0, 0, 0, 24, 0);

  // Vertical chain, each row seen on some column
  add_case(READY_ALL, LAYOUT_CHAIN, PASS, PASS, PASS, PASS,
           3, 2, 1, 0, 24, 0);
  add_case(READY_ALL, LAYOUT_CHAIN, PASS, PASS, PASS, PASS,
           0, 1, 2, 4, 24, 15);

  // Neighbour reads across columns, edges give zero
  add_case(READY_ALL, LAYOUT_MESH, ADD, MUL, XOR, SUB,
           1, 2, 3, 3, 24, 20);

  // Independent columns under back-pressure
  add_case(READY_SINGLE, LAYOUT_ROW0, SHL, ADD, OR, MUL,
           0, 4, 4, 2, 24, 30);
  add_case(READY_TWIN, LAYOUT_ROW0, XOR, SUB, AND, ADD,
           2, 3, 0, 1, 24, 25);

  // Mode code 3 groups as pairs too
  add_case(ready_mode_e'(2'd3), LAYOUT_ROW0, MUL, PASS, SHL, OR,
           4, 0, 3, 0, 24, 40);
endtask

// ==== tb/tb_pea.sv ====
`timescale 1ns/1ps

module tb_pea
  import pea_pkg::*;
();

  localparam int SEL_W        = $clog2(N_ROWS + 1);
  localparam int LAYOUT_ROW0  = 0;
  localparam int LAYOUT_CHAIN = 1;
  localparam int LAYOUT_MESH  = 2;
  localparam int DRAIN_CYCLES = 12;

  typedef struct {
    ready_mode_e      mode;
    int               layout;
    pe_op_e           ops [N_COLS];
    logic [SEL_W-1:0] sel [N_COLS];
    int               n_words;
    int               drop_pct;
  } case_t;

  logic                                      clk_i;
  logic                                      rst_n_i;
  ready_mode_e                               ready_mode;
  logic [N_COLS-1:0][SEL_W-1:0]              out_row_sel;
  pe_ctrl_t [N_ROWS-1:0][N_COLS-1:0]         ctrl_pea;
  logic [N_ROWS-1:0][N_COLS-1:0][N_BITS-1:0] const_op;
  logic [N_COLS-1:0]                         stream_valid_i;
  logic [N_COLS-1:0][N_BITS-1:0]             stream_data_i;
  logic [N_COLS-1:0]                         stream_ready_i;
  logic [N_COLS-1:0]                         pea_ready_o;
  logic [N_COLS-1:0]                         stream_valid_o;
  logic [N_COLS-1:0][N_BITS-1:0]             stream_data_o;

  case_t             case_q [$];
  logic [31:0]       lcg_state;
  int                cycles;
  int                cycle_limit;
  int                accepted [N_COLS];
  logic [N_BITS-1:0] exp_q [N_COLS][$];

  // Shadow of the array state, advanced on the same enabled edges
  logic [N_BITS-1:0] m_in_d [N_COLS];
  logic              m_in_v [N_COLS];
  logic [N_BITS-1:0] m_res [N_ROWS][N_COLS];
  logic              m_val [N_ROWS][N_COLS];

  pea #(
    .N_ROWS (N_ROWS),
    .N_COLS (N_COLS),
    .N_BITS (N_BITS)
  ) uut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ready_mode_i   (ready_mode),
    .out_row_sel_i  (out_row_sel),
    .ctrl_pea_i     (ctrl_pea),
    .const_op_i     (const_op),
    .stream_valid_i (stream_valid_i),
    .stream_data_i  (stream_data_i),
    .stream_ready_i (stream_ready_i),
    .pea_ready_o    (pea_ready_o),
    .stream_valid_o (stream_valid_o),
    .stream_data_o  (stream_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers and expected behaviour
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_pct();
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % 100;
  endfunction

  task automatic add_case(input ready_mode_e mode, input int layout,
                          input pe_op_e o0, input pe_op_e o1, input pe_op_e o2,
                          input pe_op_e o3, input int s0, input int s1, input int s2,
                          input int s3, input int n_words, input int drop_pct);
    case_t tc;
    tc.mode     = mode;
    tc.layout   = layout;
    tc.ops      = '{o0, o1, o2, o3};
    tc.sel      = '{SEL_W'(s0), SEL_W'(s1), SEL_W'(s2), SEL_W'(s3)};
    tc.n_words  = n_words;
    tc.drop_pct = drop_pct;
    case_q.push_back(tc);
  endtask

  `include "tb_pea_cases.svh"

  // ALL joins every column, TWIN joins 2k with 2k+1
  function automatic logic [N_COLS-1:0] group_ready(input ready_mode_e mode,
                                                     input logic [N_COLS-1:0] rdy);
    logic [N_COLS-1:0] grp;
    for (int c = 0; c < N_COLS; c++) begin
      if (mode == READY_ALL) begin
        grp[c] = &rdy;
      end else if (mode == READY_SINGLE) begin
        grp[c] = rdy[c];
      end else begin
        grp[c] = rdy[c & ~1] & rdy[c | 1];
      end
    end
    return grp;
  endfunction

  function automatic logic [N_BITS-1:0] expected_op(input pe_op_e op,
                                                    input logic [N_BITS-1:0] a,
                                                    input logic [N_BITS-1:0] b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      MUL:     return a * b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SHL:     return a << b[4:0];
      default: return a;
    endcase
  endfunction

  // Grid edges read as a valid zero
  task automatic pick_src(input int r, input int c, input pe_src_e code,
                          output logic [N_BITS-1:0] d, output logic v);
    d = '0;
    v = 1'b1;
    case (code)
      SRC_STREAM: begin
        d = m_in_d[c];
        v = m_in_v[c];
      end
      SRC_CONST: d = const_op[r][c];
      SRC_NORTH: if (r > 0) begin
        d = m_res[r-1][c];
        v = m_val[r-1][c];
      end
      SRC_WEST: if (c > 0) begin
        d = m_res[r][c-1];
        v = m_val[r][c-1];
      end
      SRC_EAST: if (c < N_COLS - 1) begin
        d = m_res[r][c+1];
        v = m_val[r][c+1];
      end
      SRC_SOUTH: if (r < N_ROWS - 1) begin
        d = m_res[r+1][c];
        v = m_val[r+1][c];
      end
      default: ;
    endcase
  endtask

  task automatic clear_model();
    for (int c = 0; c < N_COLS; c++) begin
      m_in_d[c] = '0;
      m_in_v[c] = 1'b0;
      exp_q[c].delete();
      for (int r = 0; r < N_ROWS; r++) begin
        m_res[r][c] = '0;
        m_val[r][c] = 1'b0;
      end
    end
  endtask

  task automatic push_expected(input logic [N_COLS-1:0] en);
    int row;
    for (int c = 0; c < N_COLS; c++) begin
      row = int'(out_row_sel[c]);
      if (row < N_ROWS && en[c] && m_val[row][c]) begin
        exp_q[c].push_back(m_res[row][c]);
      end
    end
  endtask

  task automatic advance_model(input logic [N_COLS-1:0] en);
    logic [N_BITS-1:0] nres [N_ROWS][N_COLS];
    logic              nval [N_ROWS][N_COLS];
    logic [N_BITS-1:0] a;
    logic [N_BITS-1:0] b;
    logic              va;
    logic              vb;
    for (int r = 0; r < N_ROWS; r++) begin
      for (int c = 0; c < N_COLS; c++) begin
        pick_src(r, c, ctrl_pea[r][c].src_a, a, va);
        pick_src(r, c, ctrl_pea[r][c].src_b, b, vb);
        nres[r][c] = en[c] ? expected_op(ctrl_pea[r][c].op, a, b) : m_res[r][c];
        nval[r][c] = en[c] ? (va & vb) : m_val[r][c];
      end
    end
    m_res = nres;
    m_val = nval;
    for (int c = 0; c < N_COLS; c++) begin
      if (en[c]) begin
        m_in_d[c] = stream_data_i[c];
        m_in_v[c] = stream_valid_i[c];
        if (stream_valid_i[c]) begin
          accepted[c]++;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_word(input int col, input logic [N_BITS-1:0] got,
                            input logic [N_BITS-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: column %0d data %h, expected %h", $time, col, got, exp);
      $display("TEST FAILED");
      $fatal(1, "output word differs from the model");
    end
  endtask

  task automatic check_ready(input logic [N_COLS-1:0] got, input logic [N_COLS-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: pea_ready_o %b, expected %b", $time, got, exp);
      $display("TEST FAILED");
      $fatal(1, "ready grouping differs from the rule");
    end
  endtask

  task automatic check_valid(input int col, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: column %0d valid %b, expected %b", $time, col, got, exp);
      $display("TEST FAILED");
      $fatal(1, "output valid differs from the model");
    end
  endtask

  // Outputs are stable at the falling edge
  task automatic run_cycle();
    logic [N_COLS-1:0] en;
    @(negedge clk_i);
    en = group_ready(ready_mode, stream_ready_i);
    check_ready(pea_ready_o, en);
    push_expected(en);
    for (int c = 0; c < N_COLS; c++) begin
      if (int'(out_row_sel[c]) >= N_ROWS) begin
        check_valid(c, stream_valid_o[c], 1'b0);
        check_word(c, stream_data_o[c], '0);
      end
      if (stream_valid_o[c] && pea_ready_o[c]) begin
        if (exp_q[c].size() == 0) begin
          $display("Column %0d sent a word at %0t that the model did not expect", c, $time);
          $display("TEST FAILED");
          $fatal(1, "unexpected output transfer");
        end
        check_word(c, stream_data_o[c], exp_q[c].pop_front());
      end
    end
    advance_model(en);
    @(posedge clk_i);
    #1;
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the stream did not finish", cycles);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  endtask

  task automatic apply_config(input case_t tc);
    for (int r = 0; r < N_ROWS; r++) begin
      for (int c = 0; c < N_COLS; c++) begin
        const_op[r][c] = 32'h0101_0000 + N_BITS'(r * 16 + c * 4 + 3);
        ctrl_pea[r][c] = '{PASS, SRC_STREAM, SRC_CONST};
        if (tc.layout == LAYOUT_CHAIN) begin
          // Row 0 adds the zero above the grid
          if (r == 0) begin
            ctrl_pea[r][c] = '{ADD, SRC_STREAM, SRC_NORTH};
          end else begin
            ctrl_pea[r][c] = '{PASS, SRC_NORTH, SRC_CONST};
          end
        end else if (r == 0) begin
          ctrl_pea[r][c] = '{tc.ops[c], SRC_STREAM, SRC_CONST};
        end else if (tc.layout == LAYOUT_MESH) begin
          if (r == 1) begin
            ctrl_pea[r][c] = '{ADD, SRC_NORTH, SRC_WEST};
          end else if (r == 2) begin
            ctrl_pea[r][c] = '{SUB, SRC_EAST, SRC_NORTH};
          end else begin
            ctrl_pea[r][c] = '{XOR, SRC_SOUTH, SRC_NORTH};
          end
        end
      end
    end
    for (int c = 0; c < N_COLS; c++) begin
      out_row_sel[c] = tc.sel[c];
    end
    ready_mode = tc.mode;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    case_t tc;
    logic  busy;
    lcg_state      = 32'h8a45_a0e0;
    rst_n_i        = 1'b0;
    ready_mode     = READY_ALL;
    out_row_sel    = '0;
    ctrl_pea       = '0;
    const_op       = '0;
    stream_valid_i = '0;
    stream_data_i  = '0;
    stream_ready_i = '0;
    cycles         = 0;
    load_cases();
    cycle_limit = 0;
    foreach (case_q[i]) begin
      cycle_limit += case_q[i].n_words * 20;
    end

    foreach (case_q[i]) begin
      tc = case_q[i];
      @(posedge clk_i);
      #1;
      rst_n_i        = 1'b0;
      stream_valid_i = '0;
      stream_ready_i = '0;
      apply_config(tc);
      clear_model();
      for (int c = 0; c < N_COLS; c++) begin
        accepted[c] = 0;
      end
      repeat (8) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      @(negedge clk_i);
      for (int c = 0; c < N_COLS; c++) begin
        check_valid(c, stream_valid_o[c], 1'b0);
      end
      @(posedge clk_i);
      #1;

      busy = 1'b1;
      while (busy) begin
        busy = 1'b0;
        for (int c = 0; c < N_COLS; c++) begin
          stream_ready_i[c] = (rand_pct() >= tc.drop_pct);
          stream_data_i[c]  = next_rand();
          stream_valid_i[c] = (accepted[c] < tc.n_words) && (rand_pct() >= 12);
          if (accepted[c] < tc.n_words) begin
            busy = 1'b1;
          end
        end
        run_cycle();
      end

      // Flush the pipelines with idle slots
      stream_valid_i = '0;
      stream_ready_i = '1;
      repeat (DRAIN_CYCLES) run_cycle();
      for (int c = 0; c < N_COLS; c++) begin
        if (exp_q[c].size() != 0) begin
          $display("Column %0d lost %0d expected words in case %0d", c, exp_q[c].size(), i);
          $display("TEST FAILED");
          $fatal(1, "expected words missing at the output");
        end
      end
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+tb
logic/pea_pkg.sv
logic/pea_stream_in.sv
logic/pe.sv
logic/pea_interconnect.sv
logic/pea.sv
tb/tb_pea.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PE array testbench with Verilator.
# The exit status is the simulator's, nonzero on failure.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing \
  -f files.f \
  --top-module tb_pea \
  -o Vtb_pea
status=$?
if [ $status -ne 0 ]; then
  echo "Compilation failed with status $status"
  exit $status
fi

./obj_dir/Vtb_pea
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished"
exit 0
